// ==== design/ldpc_circulant_rows.sv ====
`default_nettype none

module ldpc_circulant_rows #(
    parameter int K_LONG = 256
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clk_en,
    input  ldpc_code_pkg::code_cfg_t cfg,
    input  logic                     row_restart,
    input  logic                     row_step,
    output logic [K_LONG-1:0]        row
);

    localparam int LW = ldpc_code_pkg::P_MAX_WIDTH;

    ldpc_code_pkg::block_len_e len;
    ldpc_code_pkg::code_rate_e rate;

    logic [K_LONG-1:0] mask;
    logic [K_LONG-1:0] top_bit;
    logic [K_LONG-1:0] row_q;
    logic [K_LONG-1:0] seed_first;
    logic [K_LONG-1:0] seed_next;
    logic [K_LONG-1:0] rotated;
    logic [LW-1:0]     step_cnt;
    logic [LW-1:0]     step_next;
    logic [1:0]        circ_idx;
    logic [1:0]        idx_base;
    logic [1:0]        idx_next;
    logic              wrap;

    // Mode recovered from the two lengths
    always_comb begin
        len = (cfg.k_len == LW'(K_LONG)) ? ldpc_code_pkg::len_long : ldpc_code_pkg::len_short;
        if (!cfg.legal) begin
            rate = ldpc_code_pkg::rate_reserved;
        end else if (cfg.p_len == cfg.k_len) begin
            rate = ldpc_code_pkg::rate_1_2;
        end else if (cfg.p_len == (cfg.k_len >> 1)) begin
            rate = ldpc_code_pkg::rate_2_3;
        end else begin
            rate = ldpc_code_pkg::rate_4_5;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mask       = {K_LONG{1'b1}} >> (K_LONG - cfg.p_len);
        top_bit    = mask ^ (mask >> 1);
        idx_base   = row_restart ? 2'd0 : circ_idx;
        idx_next   = idx_base + 2'd1;
        step_next  = (row_restart ? LW'(0) : step_cnt) + 1'b1;
        wrap       = (step_next == cfg.p_len);
        seed_first = K_LONG'(ldpc_code_pkg::circulant_seed(len, rate, 2'd0)) & mask;
        seed_next  = K_LONG'(ldpc_code_pkg::circulant_seed(len, rate, idx_next)) & mask;
        row        = row_restart ? seed_first : row_q;
        // Left rotate inside p_len bits
        rotated    = ((row << 1) & mask) | K_LONG'(|(row & top_bit));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step_cnt <= '0;
            circ_idx <= '0;
        end else if (clk_en) begin
            if (row_step) begin
                step_cnt <= wrap ? LW'(0) : step_next;
                circ_idx <= wrap ? idx_next : idx_base;
            end else if (row_restart) begin
                step_cnt <= '0;
                circ_idx <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && row_step) begin
            row_q <= wrap ? seed_next : rotated;
        end
    end

endmodule

`default_nettype wire

// ==== design/ldpc_code_pkg.sv ====
`default_nettype none

package ldpc_code_pkg;

    //////////////////////////////////////////////////////////////////////
    // Mode encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        rate_1_2      = 2'd0,
        rate_2_3      = 2'd1,
        rate_4_5      = 2'd2,
        rate_reserved = 2'd3
    } code_rate_e;

    typedef enum logic {
        len_short = 1'b0,
        len_long  = 1'b1
    } block_len_e;

    // Length counters hold up to 256
    localparam int P_MAX_WIDTH = 9;
    localparam int SEED_WIDTH  = 256;

    typedef struct packed {
        logic                   legal;
        logic                   encode;
        logic [P_MAX_WIDTH-1:0] k_len;
        logic [P_MAX_WIDTH-1:0] p_len;
    } code_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // Generator helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [P_MAX_WIDTH-1:0] parity_len(
        input code_rate_e             rate,
        input logic [P_MAX_WIDTH-1:0] k
    );
        logic [P_MAX_WIDTH-1:0] p;
        case (rate)
            rate_1_2: p = k;
            rate_2_3: p = k >> 1;
            rate_4_5: p = k >> 2;
            default:  p = '0;
        endcase
        return p;
    endfunction

    // One seed per circulant, tagged by mode so that every mode differs
    function automatic logic [SEED_WIDTH-1:0] circulant_seed(
        input block_len_e len,
        input code_rate_e rate,
        input logic [1:0] idx
    );
        logic [63:0] base;
        logic [7:0]  tag;
        logic [63:0] w;
        case (idx)
            2'd0:    base = 64'h9e37_79b9_7f4a_7c15;
            2'd1:    base = 64'hc2b2_ae3d_27d4_eb4f;
            2'd2:    base = 64'h1656_67b1_9e37_79f9;
            default: base = 64'hd6e8_feb8_6659_fd93;
        endcase
        tag = {len, rate, idx, 3'b011};
        w   = base ^ {8{tag}};
        // Low word is used by the short parity widths
        return {w ^ 64'ha5a5_a5a5_a5a5_a5a5, {w[31:0], w[63:32]}, ~w, w};
    endfunction

endpackage

`default_nettype wire

// ==== design/ldpc_code_select.sv ====
`default_nettype none

module ldpc_code_select #(
    parameter int K_SHORT = 64,
    parameter int K_LONG  = 256
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clk_en,
    input  logic                       sync,
    input  logic                       start,
    input  ldpc_code_pkg::block_len_e  blocksize,
    input  ldpc_code_pkg::code_rate_e  rate,
    input  logic                       encode,
    output ldpc_code_pkg::code_cfg_t   cfg
);

    localparam int LW = ldpc_code_pkg::P_MAX_WIDTH;

    ldpc_code_pkg::code_cfg_t live_cfg;
    ldpc_code_pkg::code_cfg_t held_cfg;
    logic [LW-1:0]            k_sel;

    //////////////////////////////////////////////////////////////////////
    // Mode decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (blocksize == ldpc_code_pkg::len_long) begin
            k_sel = LW'(K_LONG);
        end else begin
            k_sel = LW'(K_SHORT);
        end
        live_cfg.legal  = (rate != ldpc_code_pkg::rate_reserved);
        live_cfg.encode = encode;
        live_cfg.k_len  = k_sel;
        live_cfg.p_len  = ldpc_code_pkg::parity_len(rate, k_sel);
    end

    //////////////////////////////////////////////////////////////////////
    // Mode hold
    //////////////////////////////////////////////////////////////////////

    // Last load happens on the cycle that takes the first bit
    always_ff @(posedge clk) begin
        if (reset) begin
            held_cfg <= '0;
        end else if (clk_en && (sync || start)) begin
            held_cfg <= live_cfg;
        end
    end

    // Follows the inputs between blocks, frozen inside a block
    assign cfg = start ? live_cfg : held_cfg;

endmodule

`default_nettype wire

// ==== design/ldpc_encoder_wrapper.sv ====
`default_nettype none

module ldpc_encoder_wrapper #(
    parameter int K_SHORT = 64,
    parameter int K_LONG  = 256
) (
    input  ldpc_code_pkg::code_rate_e rate,
    input  ldpc_code_pkg::block_len_e blocksize,
    input  logic                      reset,
    input  logic                      clk,
    input  logic                      clk_en,
    input  logic                      data_in,
    input  logic                      data_in_valid,
    output logic                      data_out,
    output logic                      data_out_valid,
    input  logic                      encode,
    input  logic                      sync,
    output logic                      block_sys_in,
    output logic                      block_par_in,
    output logic                      block_end_in,
    output logic                      block_sys_out,
    output logic                      block_par_out,
    output logic                      block_end_out
);

    ldpc_code_pkg::code_cfg_t      cfg;
    ldpc_stream_pkg::bit_beat_t    beat_in;
    ldpc_stream_pkg::bit_beat_t    beat_out;
    ldpc_stream_pkg::phase_marks_t marks_in;
    ldpc_stream_pkg::phase_marks_t marks_out;
    logic                          enc_idle;

    ldpc_code_select #(
        .K_SHORT (K_SHORT),
        .K_LONG  (K_LONG)
    ) u_select (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .sync      (sync),
        .start     (enc_idle),
        .blocksize (blocksize),
        .rate      (rate),
        .encode    (encode),
        .cfg       (cfg)
    );

    ldpc_qc_encoder #(
        .K_LONG (K_LONG)
    ) u_encoder (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .cfg       (cfg),
        .sync      (sync),
        .bit_in    (beat_in),
        .bit_out   (beat_out),
        .marks_in  (marks_in),
        .marks_out (marks_out),
        .idle      (enc_idle)
    );

    // Scalar ports to stream types and back
    assign beat_in        = '{data: data_in, valid: data_in_valid};
    assign data_out       = beat_out.data;
    assign data_out_valid = beat_out.valid;
    assign block_sys_in   = marks_in.sys;
    assign block_par_in   = marks_in.par;
    assign block_end_in   = marks_in.last;
    assign block_sys_out  = marks_out.sys;
    assign block_par_out  = marks_out.par;
    assign block_end_out  = marks_out.last;

endmodule

`default_nettype wire

// ==== design/ldpc_qc_encoder.sv ====
`default_nettype none

module ldpc_qc_encoder #(
    parameter int K_LONG = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_en,
    input  ldpc_code_pkg::code_cfg_t      cfg,
    input  logic                          sync,
    input  ldpc_stream_pkg::bit_beat_t    bit_in,
    output ldpc_stream_pkg::bit_beat_t    bit_out,
    output ldpc_stream_pkg::phase_marks_t marks_in,
    output ldpc_stream_pkg::phase_marks_t marks_out,
    output logic                          idle
);

    localparam int LW = ldpc_code_pkg::P_MAX_WIDTH;

    ldpc_stream_pkg::enc_state_e state;

    logic [LW-1:0]     bit_cnt;
    logic [LW-1:0]     par_cnt;
    logic [K_LONG-1:0] acc;
    logic [K_LONG-1:0] acc_base;
    logic [K_LONG-1:0] acc_next;
    logic [K_LONG-1:0] shifter;
    logic [K_LONG-1:0] row;
    logic              accept;
    logic              last_info;
    logic              in_sys;
    logic              in_par;

    ldpc_circulant_rows #(
        .K_LONG (K_LONG)
    ) u_rows (
        .clk         (clk),
        .reset       (reset),
        .clk_en      (clk_en),
        .cfg         (cfg),
        .row_restart (idle),
        .row_step    (accept),
        .row         (row)
    );

    //////////////////////////////////////////////////////////////////////
    // Acceptance and accumulation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        idle      = (state == ldpc_stream_pkg::st_idle);
        in_sys    = (state == ldpc_stream_pkg::st_systematic);
        in_par    = (state == ldpc_stream_pkg::st_parity);
        accept    = clk_en && !sync && bit_in.valid && cfg.legal && !in_par;
        last_info = (bit_cnt == cfg.k_len - 1'b1);
        acc_base  = idle ? '0 : acc;
        acc_next  = bit_in.data ? (acc_base ^ row) : acc_base;
    end

    // Source held off once the last systematic bit has left
    assign marks_in.sys  = cfg.legal & in_sys;
    assign marks_in.par  = cfg.legal & in_par & ~marks_out.sys;
    assign marks_in.last = cfg.legal & in_sys & last_info;

    //////////////////////////////////////////////////////////////////////
    // State machine and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ldpc_stream_pkg::st_idle;
            bit_cnt   <= '0;
            par_cnt   <= '0;
            bit_out   <= '0;
            marks_out <= '0;
        end else if (clk_en) begin
            bit_out   <= '0;
            marks_out <= '0;
            if (sync) begin
                state   <= ldpc_stream_pkg::st_idle;
                bit_cnt <= '0;
                par_cnt <= '0;
            end else if (accept) begin
                bit_out       <= '{data: bit_in.data, valid: 1'b1};
                marks_out.sys <= 1'b1;
                if (last_info) begin
                    bit_cnt        <= '0;
                    marks_out.last <= ~cfg.encode;
                    if (cfg.encode) begin
                        state   <= ldpc_stream_pkg::st_parity;
                        par_cnt <= cfg.p_len;
                    end else begin
                        state <= ldpc_stream_pkg::st_idle;
                    end
                end else begin
                    state   <= ldpc_stream_pkg::st_systematic;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (in_par) begin
                bit_out        <= '{data: shifter[K_LONG-1], valid: 1'b1};
                marks_out.par  <= 1'b1;
                marks_out.last <= (par_cnt == LW'(1));
                par_cnt        <= par_cnt - 1'b1;
                if (par_cnt == LW'(1)) begin
                    state <= ldpc_stream_pkg::st_idle;
                end
            end
        end
    end

    // Parity is left aligned so the MSB shifts out first
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (accept) begin
                acc <= acc_next;
                if (last_info) begin
                    shifter <= acc_next << (K_LONG - cfg.p_len);
                end
            end else if (in_par) begin
                shifter <= shifter << 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ldpc_stream_pkg.sv ====
`default_nettype none

package ldpc_stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // Serial stream types
    //////////////////////////////////////////////////////////////////////

    // One bit with its strobe
    typedef struct packed {
        logic data;
        logic valid;
    } bit_beat_t;

    // Block phase markers
    typedef struct packed {
        logic sys;
        logic par;
        logic last;
    } phase_marks_t;

    //////////////////////////////////////////////////////////////////////
    // Encoder control
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_systematic = 2'd1,
        st_parity     = 2'd2
    } enc_state_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LDPC encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ldpc_encoder_tb \
    -f sources.f -o ldpc_encoder_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ldpc_encoder_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== sources.f ====
design/ldpc_code_pkg.sv
design/ldpc_stream_pkg.sv
design/ldpc_code_select.sv
design/ldpc_circulant_rows.sv
design/ldpc_qc_encoder.sv
design/ldpc_encoder_wrapper.sv
verification/ldpc_encoder_checker.sv
verification/ldpc_encoder_tb.sv

// ==== verification/ldpc_encoder_checker.sv ====
`default_nettype none

module ldpc_encoder_checker (
    input logic clk,
    input logic reset,
    input logic data_out,
    input logic data_out_valid,
    input logic block_sys_in,
    input logic block_par_in,
    input logic block_end_in,
    input logic block_sys_out,
    input logic block_par_out,
    input logic block_end_out
);

    //////////////////////////////////////////////////////////////////////
    // Marker and valid protocol
    //////////////////////////////////////////////////////////////////////

    sys_par_apart: assert property (@(posedge clk) disable iff (reset)
        !(block_sys_out && block_par_out))
        else $error("block_sys_out and block_par_out high together");

    marks_need_valid: assert property (@(posedge clk) disable iff (reset)
        (block_sys_out || block_par_out) |-> data_out_valid)
        else $error("output phase marker without data_out_valid");

    end_needs_valid: assert property (@(posedge clk) disable iff (reset)
        block_end_out |-> data_out_valid)
        else $error("block_end_out without data_out_valid");

    hold_off_apart: assert property (@(posedge clk) disable iff (reset)
        !(block_par_in && block_sys_out))
        else $error("block_par_in high with block_sys_out");

    // Everything quiet right after a reset cycle
    low_after_reset: assert property (@(posedge clk)
        $past(reset) |-> !(data_out || data_out_valid || block_sys_in || block_par_in
                           || block_end_in || block_sys_out || block_par_out
                           || block_end_out))
        else $error("outputs not low after reset");

endmodule

bind ldpc_encoder_wrapper ldpc_encoder_checker u_checker (.*);

`default_nettype wire

// ==== verification/ldpc_encoder_tb.sv ====
`default_nettype none

module ldpc_encoder_tb;

    localparam int K_SHORT = 64;
    localparam int K_LONG  = 256;

    // One expected output beat
    typedef struct packed {
        logic                          data;
        ldpc_stream_pkg::phase_marks_t marks;
    } exp_beat_t;

    logic clk = 1'b0;
    logic reset;
    logic clk_en;
    logic data_in;
    logic data_in_valid;
    logic encode;
    logic sync;
    ldpc_code_pkg::block_len_e blocksize;
    ldpc_code_pkg::code_rate_e rate;
    logic data_out, data_out_valid, block_sys_out, block_par_out, block_end_out;
    logic block_sys_in, block_par_in, block_end_in;

    exp_beat_t   exp_q[$];
    exp_beat_t   exp_beat;
    logic [7:0]  out_now;
    logic [7:0]  out_prev;
    logic        prev_en;
    logic        en_random;
    logic        en_pick;
    logic [31:0] en_rnd;
    integer      seed;
    integer      en_seed;

    ldpc_encoder_wrapper #(.K_SHORT(K_SHORT), .K_LONG(K_LONG)) UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        en_pick = en_random;
        #1;
        en_rnd = $random(en_seed);
        clk_en = en_pick ? en_rnd[0] : 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("** Error %s expected %h actual %h",
                                     name, expected, actual));
    endtask

    // Parity from the circulant row rule
    function automatic logic [K_LONG-1:0] model_parity(
        input ldpc_code_pkg::block_len_e len,
        input ldpc_code_pkg::code_rate_e mode_rate,
        input logic [K_LONG-1:0]         info,
        input int                        k,
        input int                        p
    );
        logic [K_LONG-1:0] seed_v;
        logic [K_LONG-1:0] par;
        int                i;
        int                j;
        par = '0;
        for (i = 0; i < k; i++) begin
            if (info[i]) begin
                seed_v = ldpc_code_pkg::circulant_seed(len, mode_rate, 2'(i / p));
                for (j = 0; j < p; j++) begin
                    par[(j + i % p) % p] ^= seed_v[j];
                end
            end
        end
        return par;
    endfunction

    // Output monitor pops one expected beat per enabled cycle
    always @(posedge clk) begin
        out_now = {data_out_valid, data_out, block_sys_out, block_par_out, block_end_out,
                   block_sys_in, block_par_in, block_end_in};
        if (!reset && !prev_en) begin
            check_value("held outputs", out_prev, out_now);
        end
        if (!reset && clk_en) begin
            if (exp_q.size() == 0) begin
                check_value("data_out_valid", 8'h00, 8'(data_out_valid));
                check_value("block_par_in", 8'h00, 8'(block_par_in));
            end else begin
                exp_beat = exp_q.pop_front();
                check_value("data_out_valid", 8'h01, 8'(data_out_valid));
                check_value("data_out", 8'(exp_beat.data), 8'(data_out));
                check_value("block_sys_out", 8'(exp_beat.marks.sys), 8'(block_sys_out));
                check_value("block_par_out", 8'(exp_beat.marks.par), 8'(block_par_out));
                check_value("block_end_out", 8'(exp_beat.marks.last), 8'(block_end_out));
                // Source held off while parity beats other than the last are shown
                check_value("block_par_in",
                            8'(exp_beat.marks.par && !exp_beat.marks.last),
                            8'(block_par_in));
            end
        end
        out_prev = out_now;
        prev_en  = reset || clk_en;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic wait_enabled_edge(input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!clk_en) begin
            n++;
            if (n > 100) begin
                abort_run({"Timed out waiting for ", what});
            end
            @(posedge clk);
        end
        #1;
    endtask

    task automatic drain_outputs();
        logic [31:0] rnd;
        int          n;
        n = 0;
        while (exp_q.size() != 0) begin
            // Offered only while held off, so these must be dropped
            rnd           = $random(seed);
            data_in       = rnd[0];
            data_in_valid = block_par_in;
            n++;
            if (n > 2000) begin
                abort_run("Timed out waiting for the block's outputs");
            end
            @(posedge clk);
            #1;
        end
        data_in_valid = 1'b0;
    endtask

    task automatic pulse_sync();
        sync = 1'b1;
        wait_enabled_edge("the sync pulse to be taken");
        sync = 1'b0;
    endtask

    // abort_after of 0 sends the whole block
    task automatic run_block(
        input ldpc_code_pkg::block_len_e len,
        input ldpc_code_pkg::code_rate_e mode_rate,
        input logic                      enc,
        input int                        abort_after
    );
        logic [K_LONG-1:0] info;
        logic [K_LONG-1:0] par;
        logic [31:0]       rnd;
        exp_beat_t         e;
        int                k;
        int                p;
        int                n;
        int                i;
        k = (len == ldpc_code_pkg::len_long) ? K_LONG : K_SHORT;
        p = (mode_rate == ldpc_code_pkg::rate_1_2) ? k :
            (mode_rate == ldpc_code_pkg::rate_2_3) ? k / 2 : k / 4;
        n = (abort_after > 0) ? abort_after : k;
        blocksize = len;
        rate      = mode_rate;
        encode    = enc;
        info      = '0;
        for (i = 0; i < k; i++) begin
            rnd     = $random(seed);
            info[i] = rnd[0];
        end
        for (i = 0; i < n; i++) begin
            data_in       = info[i];
            data_in_valid = 1'b1;
            check_value("block_sys_in", 8'(i != 0), 8'(block_sys_in));
            check_value("block_end_in", 8'(i == k - 1), 8'(block_end_in));
            wait_enabled_edge("an information bit to be taken");
            e.data       = info[i];
            e.marks.sys  = 1'b1;
            e.marks.par  = 1'b0;
            e.marks.last = !enc && (i == k - 1);
            exp_q.push_back(e);
        end
        data_in_valid = 1'b0;
        if (n < k) begin
            pulse_sync();
        end else if (enc) begin
            par = model_parity(len, mode_rate, info, k, p);
            for (i = p - 1; i >= 0; i--) begin
                e.data       = par[i];
                e.marks.sys  = 1'b0;
                e.marks.par  = 1'b1;
                e.marks.last = (i == 0);
                exp_q.push_back(e);
            end
        end
        drain_outputs();
    endtask

    // Reserved rate leaves the monitor expecting no valid beat at all
    task automatic offer_reserved();
        logic [31:0] rnd;
        int          i;
        blocksize     = ldpc_code_pkg::len_short;
        rate          = ldpc_code_pkg::rate_reserved;
        encode        = 1'b1;
        data_in_valid = 1'b1;
        for (i = 0; i < 3 * K_SHORT; i++) begin
            rnd     = $random(seed);
            data_in = rnd[0];
            @(posedge clk);
            #1;
        end
        data_in_valid = 1'b0;
    endtask

    initial begin
        seed          = 60;
        en_seed       = 60;
        en_random     = 1'b0;
        prev_en       = 1'b1;
        reset         = 1'b1;
        clk_en        = 1'b1;
        data_in       = 1'b0;
        data_in_valid = 1'b0;
        encode        = 1'b1;
        sync          = 1'b0;
        blocksize     = ldpc_code_pkg::len_short;
        rate          = ldpc_code_pkg::rate_1_2;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // All six modes with parity
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_1_2, 1'b1, 0);
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_2_3, 1'b1, 0);
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_4_5, 1'b1, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_1_2, 1'b1, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_2_3, 1'b1, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_4_5, 1'b1, 0);

        // Pass-through and reserved rate
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_2_3, 1'b0, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_1_2, 1'b0, 0);
        offer_reserved();

        // Random clock enable, then aborted blocks
        en_random = 1'b1;
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_4_5, 1'b1, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_2_3, 1'b1, 0);
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_1_2, 1'b0, 0);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_1_2, 1'b1, 37);
        run_block(ldpc_code_pkg::len_long, ldpc_code_pkg::rate_1_2, 1'b1, 0);
        en_random = 1'b0;
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_2_3, 1'b1, 21);
        run_block(ldpc_code_pkg::len_short, ldpc_code_pkg::rate_2_3, 1'b1, 0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
